//--- files.f
hdl/board_pkg.sv
hdl/board_clk_rst.sv
hdl/apb_fabric.sv
hdl/soc_ctrl.sv
hdl/gpio_ctrl.sv
hdl/board_top.sv
verif/tb_board_top.sv

//--- hdl/apb_fabric.sv
// APB fabric between the external host and the peripheral slaves
// decodes the region, selects one slave and routes its response back
module apb_fabric
  import board_pkg::*;
(
  input  logic                  clk_gen,
  input  logic                  rst_n,
  input  logic [APB_ADDR_W-1:0] paddr_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [APB_DATA_W-1:0] pwdata_i,
  input  logic [APB_DATA_W-1:0] soc_prdata_i,
  input  logic                  soc_pready_i,
  input  logic                  soc_pslverr_i,
  input  logic [APB_DATA_W-1:0] gpio_prdata_i,
  input  logic                  gpio_pready_i,
  input  logic                  gpio_pslverr_i,
  output logic                  soc_psel_o,
  output logic                  gpio_psel_o,
  output logic [APB_DATA_W-1:0] prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o
);

  localparam int unsigned REGION_W = APB_ADDR_W - OFS_W;

  logic [REGION_W-1:0] region;
  logic                soc_hit;
  logic                gpio_hit;
  logic                unmapped;
  logic                err_q;

  assign region   = paddr_i[APB_ADDR_W-1:OFS_W];
  assign soc_hit  = region == SOC_CTRL_BASE[APB_ADDR_W-1:OFS_W];
  assign gpio_hit = region == GPIO_BASE[APB_ADDR_W-1:OFS_W];
  assign unmapped = ~soc_hit & ~gpio_hit;

  assign soc_psel_o  = psel_i & soc_hit;
  assign gpio_psel_o = psel_i & gpio_hit;

  // set in the setup cycle of an unmapped access, so the error
  // answer comes in the access cycle without a wait state
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      err_q <= 1'b0;
    end else begin
      err_q <= psel_i & ~penable_i & unmapped;
    end
  end

  // response mux, write data only goes to the slaves
  always_comb begin
    prdata_o  = '0;
    pready_o  = 1'b0;
    pslverr_o = 1'b0;
    if (soc_psel_o) begin
      prdata_o  = soc_prdata_i;
      pready_o  = soc_pready_i;
      pslverr_o = soc_pslverr_i;
    end else if (gpio_psel_o) begin
      prdata_o  = gpio_prdata_i;
      pready_o  = gpio_pready_i;
      pslverr_o = gpio_pslverr_i;
    end else if (psel_i && penable_i && err_q) begin
      pready_o  = 1'b1;
      pslverr_o = 1'b1;
    end
  end

endmodule

//--- hdl/board_clk_rst.sv
// board reset conditioning and heartbeat LED
// the synchronized reset feeds every other block of the board
module board_clk_rst #(
  parameter bit          RST_ACTIVE_LOW       = 1'b1,
  parameter int unsigned CLK_LED_COUNT_LENGTH = 27
) (
  input  logic clk_gen,
  input  logic rst_board_i,
  output logic rst_sync_n_o,
  output logic rst_led_o,
  output logic clk_led_o
);

  logic                            rst_board_n;
  logic [1:0]                      rst_sync_q;
  logic [CLK_LED_COUNT_LENGTH-1:0] clk_count_q;

  // board button polarity depends on the target board
  assign rst_board_n = RST_ACTIVE_LOW ? rst_board_i : ~rst_board_i;

  // assert at once, release after two edges
  always_ff @(posedge clk_gen or negedge rst_board_n) begin
    if (!rst_board_n) begin
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign rst_sync_n_o = rst_sync_q[1];

  // free-running heartbeat counter
  always_ff @(posedge clk_gen or negedge rst_sync_n_o) begin
    if (!rst_sync_n_o) begin
      clk_count_q <= '0;
    end else begin
      clk_count_q <= clk_count_q + 1'b1;
    end
  end

  assign clk_led_o = clk_count_q[CLK_LED_COUNT_LENGTH-1];

  // debug LED shows the reset the design actually sees
  assign rst_led_o = rst_sync_n_o;

endmodule

//--- hdl/board_pkg.sv
// shared widths and address map of the board APB subsystem
// imported by every RTL module and by the testbench
package board_pkg;

  localparam int unsigned APB_ADDR_W = 12;
  localparam int unsigned APB_DATA_W = 32;
  localparam int unsigned GPIO_W     = 14;

  // each region spans 256 bytes, upper address bits pick the region
  localparam int unsigned OFS_W = 8;

  localparam logic [APB_ADDR_W-1:0] SOC_CTRL_BASE = 12'h000;
  localparam logic [APB_ADDR_W-1:0] GPIO_BASE     = 12'h100;

  // system-control registers
  localparam logic [OFS_W-1:0] SOC_EXIT_VALUE_OFS  = 8'h00;
  localparam logic [OFS_W-1:0] SOC_EXIT_VALID_OFS  = 8'h04;
  localparam logic [OFS_W-1:0] SOC_BOOT_STATUS_OFS = 8'h08;
  localparam logic [OFS_W-1:0] SOC_SCRATCH_OFS     = 8'h0C;

  // gpio registers
  localparam logic [OFS_W-1:0] GPIO_DIR_OFS = 8'h00;
  localparam logic [OFS_W-1:0] GPIO_OUT_OFS = 8'h04;
  localparam logic [OFS_W-1:0] GPIO_IN_OFS  = 8'h08;
  localparam logic [OFS_W-1:0] GPIO_SET_OFS = 8'h0C;
  localparam logic [OFS_W-1:0] GPIO_CLR_OFS = 8'h10;

endpackage

//--- hdl/board_top.sv
// board-level wrapper of the prototype: reset, heartbeat and APB peripherals
// the external host drives the APB port directly
module board_top
  import board_pkg::*;
#(
  parameter bit          RST_ACTIVE_LOW       = 1'b1,
  parameter int unsigned CLK_LED_COUNT_LENGTH = 27
) (
  input  logic                  clk_gen,
  input  logic                  rst_i,
  input  logic                  boot_select_i,
  input  logic                  execute_from_flash_i,
  input  logic [APB_ADDR_W-1:0] paddr_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [APB_DATA_W-1:0] pwdata_i,
  input  logic [GPIO_W-1:0]     gpio_i,
  output logic [APB_DATA_W-1:0] prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  output logic [GPIO_W-1:0]     gpio_o,
  output logic [GPIO_W-1:0]     gpio_oe_o,
  output logic                  exit_value_o,
  output logic                  exit_valid_o,
  output logic                  rst_led_o,
  output logic                  clk_led_o
);

  logic                  rst_sync_n;
  logic                  soc_psel;
  logic                  gpio_psel;
  logic [APB_DATA_W-1:0] soc_prdata;
  logic                  soc_pready;
  logic                  soc_pslverr;
  logic [APB_DATA_W-1:0] gpio_prdata;
  logic                  gpio_pready;
  logic                  gpio_pslverr;

  board_clk_rst #(
    .RST_ACTIVE_LOW      (RST_ACTIVE_LOW),
    .CLK_LED_COUNT_LENGTH(CLK_LED_COUNT_LENGTH)
  ) i_board_clk_rst (
    .clk_gen     (clk_gen),
    .rst_board_i (rst_i),
    .rst_sync_n_o(rst_sync_n),
    .rst_led_o   (rst_led_o),
    .clk_led_o   (clk_led_o)
  );

  apb_fabric i_apb_fabric (
    .clk_gen       (clk_gen),
    .rst_n         (rst_sync_n),
    .paddr_i       (paddr_i),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .pwdata_i      (pwdata_i),
    .soc_prdata_i  (soc_prdata),
    .soc_pready_i  (soc_pready),
    .soc_pslverr_i (soc_pslverr),
    .gpio_prdata_i (gpio_prdata),
    .gpio_pready_i (gpio_pready),
    .gpio_pslverr_i(gpio_pslverr),
    .soc_psel_o    (soc_psel),
    .gpio_psel_o   (gpio_psel),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o)
  );

  soc_ctrl i_soc_ctrl (
    .clk_gen             (clk_gen),
    .rst_n               (rst_sync_n),
    .psel_i              (soc_psel),
    .penable_i           (penable_i),
    .pwrite_i            (pwrite_i),
    .paddr_i             (paddr_i),
    .pwdata_i            (pwdata_i),
    .boot_select_i       (boot_select_i),
    .execute_from_flash_i(execute_from_flash_i),
    .prdata_o            (soc_prdata),
    .pready_o            (soc_pready),
    .pslverr_o           (soc_pslverr),
    .exit_value_o        (exit_value_o),
    .exit_valid_o        (exit_valid_o)
  );

  gpio_ctrl i_gpio_ctrl (
    .clk_gen  (clk_gen),
    .rst_n    (rst_sync_n),
    .psel_i   (gpio_psel),
    .penable_i(penable_i),
    .pwrite_i (pwrite_i),
    .paddr_i  (paddr_i),
    .pwdata_i (pwdata_i),
    .gpio_i   (gpio_i),
    .prdata_o (gpio_prdata),
    .pready_o (gpio_pready),
    .pslverr_o(gpio_pslverr),
    .gpio_o   (gpio_o),
    .gpio_oe_o(gpio_oe_o)
  );

endmodule

//--- hdl/gpio_ctrl.sv
// GPIO APB slave for the board pins
// direction and output data registers, set/clear strobes, synchronized input
module gpio_ctrl
  import board_pkg::*;
(
  input  logic                  clk_gen,
  input  logic                  rst_n,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [APB_ADDR_W-1:0] paddr_i,
  input  logic [APB_DATA_W-1:0] pwdata_i,
  input  logic [GPIO_W-1:0]     gpio_i,
  output logic [APB_DATA_W-1:0] prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  output logic [GPIO_W-1:0]     gpio_o,
  output logic [GPIO_W-1:0]     gpio_oe_o
);

  logic [OFS_W-1:0]      ofs;
  logic                  access;
  logic                  ofs_valid;
  logic                  wr_en;
  logic [APB_DATA_W-1:0] rdata;
  logic [GPIO_W-1:0]     wr_bits;
  logic [GPIO_W-1:0]     dir_q;
  logic [GPIO_W-1:0]     out_q;
  logic [GPIO_W-1:0]     in_meta_q;
  logic [GPIO_W-1:0]     in_sync_q;

  assign ofs     = paddr_i[OFS_W-1:0];
  assign access  = psel_i & penable_i;
  assign wr_en   = access & pwrite_i & ofs_valid;
  assign wr_bits = pwdata_i[GPIO_W-1:0];

  // set and clear are write-only strobes and read as zero
  always_comb begin
    ofs_valid = 1'b1;
    rdata     = '0;
    case (ofs)
      GPIO_DIR_OFS: rdata[GPIO_W-1:0] = dir_q;
      GPIO_OUT_OFS: rdata[GPIO_W-1:0] = out_q;
      GPIO_IN_OFS:  rdata[GPIO_W-1:0] = in_sync_q;
      GPIO_SET_OFS: rdata = '0;
      GPIO_CLR_OFS: rdata = '0;
      default:      ofs_valid = 1'b0;
    endcase
  end

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      dir_q <= '0;
      out_q <= '0;
    end else if (wr_en) begin
      case (ofs)
        GPIO_DIR_OFS: dir_q <= wr_bits;
        GPIO_OUT_OFS: out_q <= wr_bits;
        GPIO_SET_OFS: out_q <= out_q | wr_bits;
        GPIO_CLR_OFS: out_q <= out_q & ~wr_bits;
        default:      ;
      endcase
    end
  end

  // pins are asynchronous to clk_gen
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      in_meta_q <= '0;
      in_sync_q <= '0;
    end else begin
      in_meta_q <= gpio_i;
      in_sync_q <= in_meta_q;
    end
  end

  assign prdata_o  = (access && !pwrite_i) ? rdata : '0;
  assign pready_o  = access;
  assign pslverr_o = access & ~ofs_valid;
  assign gpio_o    = out_q;
  assign gpio_oe_o = dir_q;

endmodule

//--- hdl/soc_ctrl.sv
// system-control APB slave: exit value and flag, boot straps, scratch
// answers with no wait states, unknown offsets give an error
module soc_ctrl
  import board_pkg::*;
(
  input  logic                  clk_gen,
  input  logic                  rst_n,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [APB_ADDR_W-1:0] paddr_i,
  input  logic [APB_DATA_W-1:0] pwdata_i,
  input  logic                  boot_select_i,
  input  logic                  execute_from_flash_i,
  output logic [APB_DATA_W-1:0] prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  output logic                  exit_value_o,
  output logic                  exit_valid_o
);

  logic [OFS_W-1:0]      ofs;
  logic                  access;
  logic                  ofs_valid;
  logic                  wr_en;
  logic [APB_DATA_W-1:0] rdata;
  logic [APB_DATA_W-1:0] exit_value_q;
  logic [APB_DATA_W-1:0] scratch_q;
  logic                  exit_valid_q;
  logic [1:0]            strap_meta_q;
  logic [1:0]            strap_sync_q;
  logic [1:0]            boot_status_q;
  logic [1:0]            strap_cnt_q;

  assign ofs    = paddr_i[OFS_W-1:0];
  assign access = psel_i & penable_i;
  assign wr_en  = access & pwrite_i & ofs_valid;

  always_comb begin
    ofs_valid = 1'b1;
    rdata     = '0;
    case (ofs)
      SOC_EXIT_VALUE_OFS:  rdata = exit_value_q;
      SOC_EXIT_VALID_OFS:  rdata[0] = exit_valid_q;
      SOC_BOOT_STATUS_OFS: rdata[1:0] = boot_status_q;
      SOC_SCRATCH_OFS:     rdata = scratch_q;
      default:             ofs_valid = 1'b0;
    endcase
  end

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      exit_value_q <= '0;
      exit_valid_q <= 1'b0;
      scratch_q    <= '0;
    end else if (wr_en) begin
      case (ofs)
        SOC_EXIT_VALUE_OFS: exit_value_q <= pwdata_i;
        // sticky until reset
        SOC_EXIT_VALID_OFS: exit_valid_q <= exit_valid_q | pwdata_i[0];
        SOC_SCRATCH_OFS:    scratch_q <= pwdata_i;
        default:            ;
      endcase
    end
  end

  // straps go through two flops, latched on the third cycle after reset
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      strap_meta_q  <= 2'b00;
      strap_sync_q  <= 2'b00;
      boot_status_q <= 2'b00;
      strap_cnt_q   <= 2'd0;
    end else begin
      strap_meta_q <= {execute_from_flash_i, boot_select_i};
      strap_sync_q <= strap_meta_q;
      if (strap_cnt_q != 2'd3) begin
        strap_cnt_q <= strap_cnt_q + 2'd1;
      end
      if (strap_cnt_q == 2'd2) begin
        boot_status_q <= strap_sync_q;
      end
    end
  end

  assign prdata_o     = (access && !pwrite_i) ? rdata : '0;
  assign pready_o     = access;
  assign pslverr_o    = access & ~ofs_valid;
  assign exit_value_o = exit_value_q[0];
  assign exit_valid_o = exit_valid_q;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# builds the board testbench with Verilator and runs it
# a failing check ends the run with $fatal and a nonzero exit status
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tb_board_top \
  -f files.f \
  -o sim_board

./obj_dir/sim_board

//--- verif/tb_board_top.sv
// random APB testbench for the board wrapper, checked against a register model
// covers register access, gpio pins, error responses, exit and straps, reset and heartbeat
module tb_board_top
  import board_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned LED_LEN        = 4;
  localparam int unsigned HALF_PERIOD    = 2 ** (LED_LEN - 1);
  localparam int unsigned TIMEOUT_CYCLES = 20000;
  localparam int unsigned NUM_RW         = 40;
  localparam int unsigned NUM_GPIO       = 40;
  localparam int unsigned NUM_IN         = 20;
  localparam int unsigned NUM_ERR        = 20;

  logic                  clk_gen;
  logic                  rst_i;
  logic                  boot_select_i;
  logic                  execute_from_flash_i;
  logic [APB_ADDR_W-1:0] paddr_i;
  logic                  psel_i;
  logic                  penable_i;
  logic                  pwrite_i;
  logic [APB_DATA_W-1:0] pwdata_i;
  logic [GPIO_W-1:0]     gpio_i;
  logic [APB_DATA_W-1:0] prdata_o;
  logic                  pready_o;
  logic                  pslverr_o;
  logic [GPIO_W-1:0]     gpio_o;
  logic [GPIO_W-1:0]     gpio_oe_o;
  logic                  exit_value_o;
  logic                  exit_valid_o;
  logic                  rst_led_o;
  logic                  clk_led_o;

  // register model
  logic [APB_DATA_W-1:0] exp_exit_value;
  logic [APB_DATA_W-1:0] exp_scratch;
  logic                  exp_exit_valid;
  logic [GPIO_W-1:0]     exp_dir;
  logic [GPIO_W-1:0]     exp_out;
  logic [1:0]            exp_boot;
  int unsigned           cycles;

  board_top #(
    .RST_ACTIVE_LOW      (1'b0),
    .CLK_LED_COUNT_LENGTH(LED_LEN)
  ) i_board_top (
    .clk_gen             (clk_gen),
    .rst_i               (rst_i),
    .boot_select_i       (boot_select_i),
    .execute_from_flash_i(execute_from_flash_i),
    .paddr_i             (paddr_i),
    .psel_i              (psel_i),
    .penable_i           (penable_i),
    .pwrite_i            (pwrite_i),
    .pwdata_i            (pwdata_i),
    .gpio_i              (gpio_i),
    .prdata_o            (prdata_o),
    .pready_o            (pready_o),
    .pslverr_o           (pslverr_o),
    .gpio_o              (gpio_o),
    .gpio_oe_o           (gpio_oe_o),
    .exit_value_o        (exit_value_o),
    .exit_valid_o        (exit_valid_o),
    .rst_led_o           (rst_led_o),
    .clk_led_o           (clk_led_o)
  );

  initial begin
    clk_gen = 1'b0;
    forever #5 clk_gen = ~clk_gen;
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_gen);
      cycles++;
    end
    $display("Test failed");
    $fatal(1, "timeout: the run did not finish within the cycle limit");
  end

  function automatic logic [APB_ADDR_W-1:0] reg_addr(input logic [APB_ADDR_W-1:0] base,
                                                     input logic [OFS_W-1:0] ofs);
    logic [APB_ADDR_W-1:0] a;
    a = base;
    a[OFS_W-1:0] = ofs;
    return a;
  endfunction

  function automatic logic [APB_DATA_W-1:0] zext_gpio(input logic [GPIO_W-1:0] v);
    logic [APB_DATA_W-1:0] d;
    d = '0;
    d[GPIO_W-1:0] = v;
    return d;
  endfunction

  function automatic bit soc_ofs_known(input logic [OFS_W-1:0] ofs);
    return ofs == SOC_EXIT_VALUE_OFS || ofs == SOC_EXIT_VALID_OFS ||
           ofs == SOC_BOOT_STATUS_OFS || ofs == SOC_SCRATCH_OFS;
  endfunction

  function automatic bit gpio_ofs_known(input logic [OFS_W-1:0] ofs);
    return ofs == GPIO_DIR_OFS || ofs == GPIO_OUT_OFS || ofs == GPIO_IN_OFS ||
           ofs == GPIO_SET_OFS || ofs == GPIO_CLR_OFS;
  endfunction

  // any region other than the two mapped ones
  function automatic logic [APB_ADDR_W-1:0] pick_unmapped_addr();
    logic [APB_DATA_W-1:0] r;
    logic [APB_ADDR_W-1:0] a;
    do begin
      r = $urandom();
      a = r[APB_ADDR_W-1:0];
    end while (a[APB_ADDR_W-1:OFS_W] == SOC_CTRL_BASE[APB_ADDR_W-1:OFS_W] ||
               a[APB_ADDR_W-1:OFS_W] == GPIO_BASE[APB_ADDR_W-1:OFS_W]);
    return a;
  endfunction

  task automatic compare_data(input string name, input logic [APB_DATA_W-1:0] exp,
                              input logic [APB_DATA_W-1:0] act);
    if (act !== exp) begin
      $display("Fail %s: expected %0h, actual %0h", name, exp, act);
      $display("Test failed");
      $fatal(1, "read data mismatch");
    end
  endtask

  task automatic compare_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s: expected pslverr %0b, actual %0b", name, exp, act);
      $display("Test failed");
      $fatal(1, "error response mismatch");
    end
  endtask

  task automatic compare_gpio(input string name, input logic [GPIO_W-1:0] exp,
                              input logic [GPIO_W-1:0] act);
    if (act !== exp) begin
      $display("Fail %s: expected %0h, actual %0h", name, exp, act);
      $display("Test failed");
      $fatal(1, "gpio pin mismatch");
    end
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s: expected %0b, actual %0b", name, exp, act);
      $display("Test failed");
      $fatal(1, "status output mismatch");
    end
  endtask

  task automatic compare_count(input string name, input int unsigned exp, input int unsigned act);
    if (act != exp) begin
      $display("Fail %s: expected %0d, actual %0d", name, exp, act);
      $display("Test failed");
      $fatal(1, "cycle count mismatch");
    end
  endtask

  // one transfer, setup then access until pready
  task automatic apb_xfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                          input logic [APB_DATA_W-1:0] wdata,
                          output logic [APB_DATA_W-1:0] rdata, output logic err);
    int unsigned access_cycles;
    @(posedge clk_gen);
    #1;
    paddr_i   = addr;
    pwrite_i  = wr;
    pwdata_i  = wdata;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    @(posedge clk_gen);
    #1;
    penable_i = 1'b1;
    access_cycles = 1;
    @(negedge clk_gen);
    while (!pready_o) begin
      access_cycles++;
      @(negedge clk_gen);
    end
    // pready is due in the first access cycle
    compare_count("access cycles", 1, access_cycles);
    rdata = prdata_o;
    err   = pslverr_o;
    @(posedge clk_gen);
    #1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic apb_write(input string name, input logic [APB_ADDR_W-1:0] addr,
                           input logic [APB_DATA_W-1:0] data);
    logic [APB_DATA_W-1:0] rdata;
    logic                  err;
    apb_xfer(1'b1, addr, data, rdata, err);
    compare_err(name, 1'b0, err);
  endtask

  task automatic apb_read_check(input string name, input logic [APB_ADDR_W-1:0] addr,
                                input logic [APB_DATA_W-1:0] exp);
    logic [APB_DATA_W-1:0] rdata;
    logic                  err;
    apb_xfer(1'b0, addr, '0, rdata, err);
    compare_err(name, 1'b0, err);
    compare_data(name, exp, rdata);
  endtask

  task automatic apb_expect_error(input string name, input logic wr,
                                  input logic [APB_ADDR_W-1:0] addr,
                                  input logic [APB_DATA_W-1:0] data);
    logic [APB_DATA_W-1:0] rdata;
    logic                  err;
    apb_xfer(wr, addr, data, rdata, err);
    compare_err(name, 1'b1, err);
    compare_data(name, '0, rdata);
  endtask

  // 0 exit value, 1 scratch, 2 dir, 3 out
  task automatic write_model_reg(input int unsigned idx, input logic [APB_DATA_W-1:0] d);
    case (idx)
      0: begin
        exp_exit_value = d;
        apb_write("exit value write", reg_addr(SOC_CTRL_BASE, SOC_EXIT_VALUE_OFS), d);
        compare_flag("exit value pin", exp_exit_value[0], exit_value_o);
      end
      1: begin
        exp_scratch = d;
        apb_write("scratch write", reg_addr(SOC_CTRL_BASE, SOC_SCRATCH_OFS), d);
      end
      2: begin
        exp_dir = d[GPIO_W-1:0];
        apb_write("dir write", reg_addr(GPIO_BASE, GPIO_DIR_OFS), d);
        compare_gpio("dir pins", exp_dir, gpio_oe_o);
      end
      default: begin
        exp_out = d[GPIO_W-1:0];
        apb_write("out write", reg_addr(GPIO_BASE, GPIO_OUT_OFS), d);
        compare_gpio("out pins", exp_out, gpio_o);
      end
    endcase
  endtask

  task automatic read_model_reg(input int unsigned idx);
    case (idx)
      0: apb_read_check("exit value read", reg_addr(SOC_CTRL_BASE, SOC_EXIT_VALUE_OFS),
                        exp_exit_value);
      1: apb_read_check("scratch read", reg_addr(SOC_CTRL_BASE, SOC_SCRATCH_OFS), exp_scratch);
      2: apb_read_check("dir read", reg_addr(GPIO_BASE, GPIO_DIR_OFS), zext_gpio(exp_dir));
      default: apb_read_check("out read", reg_addr(GPIO_BASE, GPIO_OUT_OFS), zext_gpio(exp_out));
    endcase
  endtask

  task automatic check_heartbeat(input int unsigned n_runs);
    logic        level;
    int unsigned run;
    @(negedge clk_gen);
    level = clk_led_o;
    // first run may be partial
    while (clk_led_o === level) begin
      @(negedge clk_gen);
    end
    repeat (n_runs) begin
      level = clk_led_o;
      run   = 1;
      @(negedge clk_gen);
      while (clk_led_o === level) begin
        run++;
        @(negedge clk_gen);
      end
      compare_count("heartbeat run length", HALF_PERIOD, run);
    end
  endtask

  initial begin
    logic [APB_DATA_W-1:0] r;
    logic [OFS_W-1:0]      ofs;
    logic [GPIO_W-1:0]     pins;
    int unsigned           sel;

    void'($urandom(25));
    r = $urandom();
    // one strap high and the other low
    exp_boot             = r[0] ? 2'b01 : 2'b10;
    boot_select_i        = exp_boot[0];
    execute_from_flash_i = exp_boot[1];
    rst_i                = 1'b1;
    paddr_i              = '0;
    psel_i               = 1'b0;
    penable_i            = 1'b0;
    pwrite_i             = 1'b0;
    pwdata_i             = '0;
    gpio_i               = '0;
    exp_exit_value       = '0;
    exp_scratch          = '0;
    exp_exit_valid       = 1'b0;
    exp_dir              = '0;
    exp_out              = '0;

    // board reset is active high here
    repeat (2) begin
      @(negedge clk_gen);
      compare_flag("led during reset", 1'b0, rst_led_o);
    end
    @(posedge clk_gen);
    #1;
    rst_i = 1'b0;
    repeat (2) begin
      @(negedge clk_gen);
      compare_flag("led before sync release", 1'b0, rst_led_o);
    end
    @(negedge clk_gen);
    compare_flag("led after sync release", 1'b1, rst_led_o);
    compare_gpio("reset out pins", '0, gpio_o);
    compare_gpio("reset oe pins", '0, gpio_oe_o);
    compare_flag("reset exit value", 1'b0, exit_value_o);
    compare_flag("reset exit valid", 1'b0, exit_valid_o);
    compare_flag("idle pready", 1'b0, pready_o);
    compare_err("idle pslverr", 1'b0, pslverr_o);
    check_heartbeat(4);

    repeat (NUM_RW) begin
      sel = $urandom() % 4;
      write_model_reg(sel, $urandom());
      sel = $urandom() % 4;
      read_model_reg(sel);
    end

    // set and clear mixed with plain out writes
    repeat (NUM_GPIO) begin
      r   = $urandom();
      sel = $urandom() % 3;
      case (sel)
        0: write_model_reg(3, r);
        1: begin
          exp_out = exp_out | r[GPIO_W-1:0];
          apb_write("set write", reg_addr(GPIO_BASE, GPIO_SET_OFS), r);
          compare_gpio("pins after set", exp_out, gpio_o);
          apb_read_check("set read", reg_addr(GPIO_BASE, GPIO_SET_OFS), '0);
        end
        default: begin
          exp_out = exp_out & ~r[GPIO_W-1:0];
          apb_write("clr write", reg_addr(GPIO_BASE, GPIO_CLR_OFS), r);
          compare_gpio("pins after clr", exp_out, gpio_o);
          apb_read_check("clr read", reg_addr(GPIO_BASE, GPIO_CLR_OFS), '0);
        end
      endcase
      compare_gpio("oe pins", exp_dir, gpio_oe_o);
    end
    read_model_reg(3);

    repeat (NUM_IN) begin
      r      = $urandom();
      pins   = r[GPIO_W-1:0];
      gpio_i = pins;
      repeat (4) @(posedge clk_gen);
      apb_read_check("in read", reg_addr(GPIO_BASE, GPIO_IN_OFS), zext_gpio(pins));
    end

    repeat (NUM_ERR) begin
      r = $urandom();
      apb_expect_error("unmapped access", r[0], pick_unmapped_addr(), $urandom());
      do begin
        r   = $urandom();
        ofs = r[OFS_W-1:0];
      end while (soc_ofs_known(ofs));
      apb_expect_error("soc unknown offset", r[31], reg_addr(SOC_CTRL_BASE, ofs), $urandom());
      do begin
        r   = $urandom();
        ofs = r[OFS_W-1:0];
      end while (gpio_ofs_known(ofs));
      apb_expect_error("gpio unknown offset", r[31], reg_addr(GPIO_BASE, ofs), $urandom());
    end
    // nothing may have moved
    for (sel = 0; sel < 4; sel++) begin
      read_model_reg(sel);
    end
    compare_gpio("out pins after errors", exp_out, gpio_o);
    compare_gpio("oe pins after errors", exp_dir, gpio_oe_o);
    compare_flag("exit valid after errors", 1'b0, exit_valid_o);

    r = $urandom();
    write_model_reg(0, r | 32'h1);
    write_model_reg(0, r & ~32'h1);
    apb_write("exit valid clear write", reg_addr(SOC_CTRL_BASE, SOC_EXIT_VALID_OFS), r & ~32'h1);
    compare_flag("exit valid low", 1'b0, exit_valid_o);
    apb_read_check("exit valid read low", reg_addr(SOC_CTRL_BASE, SOC_EXIT_VALID_OFS), '0);
    exp_exit_valid = 1'b1;
    apb_write("exit valid set write", reg_addr(SOC_CTRL_BASE, SOC_EXIT_VALID_OFS), r | 32'h1);
    compare_flag("exit valid high", exp_exit_valid, exit_valid_o);
    apb_write("exit valid sticky write", reg_addr(SOC_CTRL_BASE, SOC_EXIT_VALID_OFS), '0);
    compare_flag("exit valid sticky", exp_exit_valid, exit_valid_o);
    apb_read_check("exit valid read high", reg_addr(SOC_CTRL_BASE, SOC_EXIT_VALID_OFS),
                   32'h1);
    apb_read_check("boot status read", reg_addr(SOC_CTRL_BASE, SOC_BOOT_STATUS_OFS),
                   {30'b0, exp_boot});

    $display("Test completed successfully");
    $finish;
  end

endmodule
